/* sim/policer_patterns.txt */
// cfg_wr cfg_port cfg_field cfg_wdata in_valid in_last in_port in_len in_data stat_sel exp_drop
// one line per cycle; exp_drop is the verdict on first beats; a line of ff ends the table.
1 1 0 00001 0 0 0 0000 0000000000000000 0 0
1 1 1 00008 1 0 0 0010 00a0000000000101 0 0
1 1 2 00040 1 1 0 0010 00a0000000000102 0 0
1 2 0 00001 1 1 0 0020 00a0000000000301 0 0
1 2 1 00001 0 0 0 0000 0000000000000000 0 0
1 2 2 00030 1 1 1 0030 00b1000000000501 1 0
0 0 0 00000 0 0 0 0000 0000000000000000 1 0
0 0 0 00000 1 0 1 0030 00b1000000000701 1 1
0 0 0 00000 1 1 1 0030 00b1000000000702 1 0
0 0 0 00000 0 0 0 0000 0000000000000000 1 0
0 0 0 00000 1 1 1 0030 00b1000000000a01 2 0
0 0 0 00000 0 0 0 0000 0000000000000000 2 0
0 0 0 00000 1 0 2 0020 00c2000000000c01 2 0
0 0 0 00000 1 1 2 0020 00c2000000000c02 2 0
0 0 0 00000 1 1 1 0028 00b1000000000e01 1 0
0 0 0 00000 0 0 0 0000 0000000000000000 1 0
0 0 0 00000 1 0 2 0020 00c2000000001001 2 1
0 0 0 00000 1 1 2 0020 00c2000000001002 2 0
1 1 0 00000 1 1 1 0030 00b1000000001201 1 1
1 2 2 00010 0 0 0 0000 0000000000000000 3 0
0 0 0 00000 1 1 1 0030 00b1000000001401 1 0
1 1 0 00001 0 0 0 0000 0000000000000000 0 0
0 0 0 00000 1 1 2 0008 00c2000000001601 2 1
0 0 0 00000 0 0 0 0000 0000000000000000 2 0
0 0 0 00000 1 1 1 0030 00b1000000001801 1 0
0 0 0 00000 0 0 0 0000 0000000000000000 0 0
ff

/* policer_subsystem.f */
+incdir+common
common/policer_pkg.sv
design/policer_config_regs.sv
policer/bucket_policer.sv
design/drop_filter.sv
design/drop_stats.sv
design/policer_subsystem.sv
sim/policer_sva.sv
sim/policer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the policer testbench with Verilator, runs it and checks the log.
# Run from anywhere; paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module policer_tb -Mdir obj_dir -f policer_subsystem.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vpolicer_tb > sim.log 2>&1
run_status=$?
cat sim.log

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^All tests passed$" sim.log; then
    exit 0
else
    echo "pass line not found in sim.log"
    exit 1
fi

/* sim/policer_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// pattern-driven testbench. one table line per clock cycle, table ends at a line of ff.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "policer_defines.svh"

module policer_tb;

    import policer_pkg::*;

    localparam int NUM_PORTS = `POLICER_NUM_PORTS;
    localparam int COLS      = 11;  // words per table line.
    localparam int MAX_LINES = 64;

    typedef struct packed {
        logic       valid;
        beat_data_t data;
        logic       last;
        port_id_t   port;
        byte_len_t  len;
    } egress_t;

    logic                         packet_in;
    logic                         rst_n;
    logic                         in_valid;
    beat_data_t                   in_data;
    logic                         in_last;
    port_id_t                     in_port;
    byte_len_t                    in_len;
    logic                         out_valid;
    beat_data_t                   out_data;
    logic                         out_last;
    port_id_t                     out_port;
    byte_len_t                    out_len;
    logic                         cfg_wr;
    port_id_t                     cfg_port;
    cfg_field_e                   cfg_field;
    logic [`POLICER_BUCKET_W-1:0] cfg_wdata;
    port_id_t                     stat_sel;
    stat_count_t                  stat_pass;
    stat_count_t                  stat_drop;

    logic [63:0] pat [0:COLS*MAX_LINES-1];
    int          num_lines;
    int          limit = 1000;
    int          cycles = 0;
    logic        exp_drop;

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model state
    // ~~~~~~~~~~~~~~~~~~~~

    int      m_bucket [NUM_PORTS];
    logic    m_en     [NUM_PORTS];
    int      m_dec    [NUM_PORTS];
    int      m_thr    [NUM_PORTS];
    int      m_pass   [NUM_PORTS];
    int      m_drop   [NUM_PORTS];
    logic    m_sop;
    logic    m_hold;  // verdict of the packet in flight.
    egress_t exp_q [$];

    policer_subsystem dut_i (.*);

    initial begin
        packet_in = 1'b0;
        forever #20 packet_in = ~packet_in;
    end

    always @(posedge packet_in) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run went past %0d cycles without finishing", limit);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        assert (got === expected) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic apply_line(input int i);
        int b;
        b = i * COLS;
        if (i < num_lines) begin
            cfg_wr    = pat[b][0];
            cfg_port  = pat[b+1][1:0];
            cfg_field = cfg_field_e'(pat[b+2][1:0]);
            cfg_wdata = pat[b+3][`POLICER_BUCKET_W-1:0];
            in_valid  = pat[b+4][0];
            in_last   = pat[b+5][0];
            in_port   = pat[b+6][1:0];
            in_len    = pat[b+7][`POLICER_LEN_W-1:0];
            in_data   = pat[b+8];
            stat_sel  = pat[b+9][1:0];
            exp_drop  = pat[b+10][0];
        end else begin
            cfg_wr   = 1'b0;  // drain cycles.
            in_valid = 1'b0;
            exp_drop = 1'b0;
        end
    endtask

    // bucket rule with this cycle's config, then the pending write lands.
    task automatic step_model();
        egress_t e;
        logic    first;
        logic    verdict;
        logic    pkt_drop;
        int      sum;
        int      nb;
        first   = in_valid && m_sop;
        verdict = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            nb = (m_bucket[p] > m_dec[p]) ? m_bucket[p] - m_dec[p] : 0;
            if (!m_en[p]) begin
                nb = 0;
            end else if (first && in_port == p) begin
                sum = m_bucket[p] + int'(in_len);
                if (sum > m_thr[p]) begin
                    verdict = 1'b1;
                end else begin
                    nb = (sum > m_dec[p]) ? sum - m_dec[p] : 0;
                end
            end
            m_bucket[p] = nb;
        end
        if (first) begin
            compare_field("model drop verdict", verdict, exp_drop);
            m_hold = verdict;
            if (verdict) begin
                m_drop[in_port]++;
            end else begin
                m_pass[in_port]++;
            end
        end
        pkt_drop = first ? verdict : m_hold;
        if (in_valid) begin
            m_sop = in_last;
        end
        e.valid = in_valid && !pkt_drop;
        e.data  = in_data;
        e.last  = in_last;
        e.port  = in_port;
        e.len   = in_len;
        exp_q.push_back(e);
        if (cfg_wr) begin
            case (cfg_field)
                CFG_ENABLE:    m_en[cfg_port]  = cfg_wdata[0];
                CFG_DECREMENT: m_dec[cfg_port] = int'(cfg_wdata[`POLICER_LEN_W-1:0]);
                CFG_THRESHOLD: m_thr[cfg_port] = int'(cfg_wdata);
                default: ;
            endcase
        end
    endtask

    // egress trails the model by one more register stage.
    task automatic check_egress();
        egress_t e;
        if (exp_q.size() < 2) begin
            return;
        end
        e = exp_q.pop_front();
        compare_field("out_valid", out_valid, e.valid);
        if (e.valid) begin
            compare_field("out_data", out_data, e.data);
            compare_field("out_last", out_last, e.last);
            compare_field("out_port", out_port, e.port);
            compare_field("out_len", out_len, e.len);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_port  = '0;
        cfg_field = CFG_ENABLE;
        cfg_wdata = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_last   = 1'b0;
        in_port   = '0;
        in_len    = '0;
        stat_sel  = '0;
        exp_drop  = 1'b0;
        m_sop     = 1'b1;
        m_hold    = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            m_bucket[p] = 0;
            m_en[p]     = 1'b0;
            m_dec[p]    = 0;
            m_thr[p]    = 0;
            m_pass[p]   = 0;
            m_drop[p]   = 0;
        end
        $readmemh("sim/policer_patterns.txt", pat);
        num_lines = 0;
        while (num_lines < MAX_LINES && pat[num_lines*COLS] != 64'hff) begin
            num_lines++;
        end
        if (num_lines == MAX_LINES) begin
            $display("Pattern table has no end line of ff");
            abort_run();
        end
        limit = num_lines + 50;

        repeat (4) @(posedge packet_in);
        #2 rst_n = 1'b1;
        for (int i = 0; i < num_lines + 4; i++) begin
            apply_line(i);
            @(posedge packet_in);
            step_model();
            #2;
            check_egress();
        end

        for (int p = 0; p < NUM_PORTS; p++) begin
            @(posedge packet_in);
            #2 stat_sel = port_id_t'(p);
            #5;
            compare_field("stat_pass", stat_pass, m_pass[p]);
            compare_field("stat_drop", stat_drop, m_drop[p]);
        end

        // any mismatch has already stopped the run.
        $display("All tests passed");
        $finish;
    end

endmodule

/* sim/policer_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~
// protocol checks on the policer top level, bound to every instance of it.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module policer_sva (
    input logic packet_in,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic fate_valid
);

    // egress stays quiet while reset is held.
    reset_quiet: assert property (@(posedge packet_in) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // every passed beat entered two cycles earlier.
    egress_latency: assert property (@(posedge packet_in) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 2))
        else $error("out_valid without an in_valid two cycles before");

    fate_spacing: assert property (@(posedge packet_in) disable iff (!rst_n)
        fate_valid |=> !fate_valid)
        else $error("fate_valid high in two consecutive cycles");

endmodule

bind policer_subsystem policer_sva sva_i (
    .packet_in  (packet_in),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .fate_valid (fate_valid)
);

/* design/policer_subsystem.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ingress policing stage. passed beats leave 2 cycles after entry.
// no back-pressure, so every beat is accepted.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "policer_defines.svh"

module policer_subsystem (
    input  logic                     packet_in,
    input  logic                     rst_n,

    input  logic                     in_valid,
    input  policer_pkg::beat_data_t  in_data,
    input  logic                     in_last,
    input  policer_pkg::port_id_t    in_port,
    input  policer_pkg::byte_len_t   in_len,

    output logic                     out_valid,
    output policer_pkg::beat_data_t  out_data,
    output logic                     out_last,
    output policer_pkg::port_id_t    out_port,
    output policer_pkg::byte_len_t   out_len,

    input  logic                     cfg_wr,
    input  policer_pkg::port_id_t    cfg_port,
    input  policer_pkg::cfg_field_e  cfg_field,
    input  logic [`POLICER_BUCKET_W-1:0] cfg_wdata,

    input  policer_pkg::port_id_t    stat_sel,
    output policer_pkg::stat_count_t stat_pass,
    output policer_pkg::stat_count_t stat_drop
);

    import policer_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // internal nets
    // ~~~~~~~~~~~~~~~~~~~~

    logic [`POLICER_NUM_PORTS-1:0] port_enable;
    bucket_decrement_t             port_decrement [`POLICER_NUM_PORTS];
    bucket_threshold_t             port_threshold [`POLICER_NUM_PORTS];

    logic       pol_valid;
    beat_data_t pol_data;
    logic       pol_last;
    port_id_t   pol_port;
    byte_len_t  pol_len;
    logic       pol_drop;

    logic       fate_valid;
    logic       fate_drop;
    port_id_t   fate_port;

    // ~~~~~~~~~~~~~~~~~~~~
    // blocks
    // ~~~~~~~~~~~~~~~~~~~~

    policer_config_regs config_regs_i (.*);

    bucket_policer bucket_policer_i (.*);

    drop_filter drop_filter_i (.*);

    drop_stats drop_stats_i (.*);

endmodule

/* design/drop_stats.sv */
// ~~~~~~~~~~~~~~~~~~~~
// pass and drop packet counts per port. counters stick at all ones.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "policer_defines.svh"

module drop_stats (
    input  logic                     packet_in,
    input  logic                     rst_n,

    input  logic                     fate_valid,
    input  logic                     fate_drop,
    input  policer_pkg::port_id_t    fate_port,

    input  policer_pkg::port_id_t    stat_sel,
    output policer_pkg::stat_count_t stat_pass,
    output policer_pkg::stat_count_t stat_drop
);

    import policer_pkg::*;

    localparam int NUM_PORTS = `POLICER_NUM_PORTS;

    stat_count_t pass_cnt [NUM_PORTS];
    stat_count_t drop_cnt [NUM_PORTS];

    // ~~~~~~~~~~~~~~~~~~~~
    // counters
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            pass_cnt <= '{default: '0};
            drop_cnt <= '{default: '0};
        end else if (fate_valid) begin
            if (fate_drop) begin
                if (drop_cnt[fate_port] != '1) begin
                    drop_cnt[fate_port] <= drop_cnt[fate_port] + 1'b1;
                end
            end else begin
                if (pass_cnt[fate_port] != '1) begin
                    pass_cnt[fate_port] <= pass_cnt[fate_port] + 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~

    assign stat_pass = pass_cnt[stat_sel];  // combinational read.
    assign stat_drop = drop_cnt[stat_sel];

endmodule

/* design/drop_filter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// removes every beat of a packet whose first beat carries pol_drop.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "policer_defines.svh"

module drop_filter (
    input  logic                    packet_in,
    input  logic                    rst_n,

    input  logic                    pol_valid,
    input  policer_pkg::beat_data_t pol_data,
    input  logic                    pol_last,
    input  policer_pkg::port_id_t   pol_port,
    input  policer_pkg::byte_len_t  pol_len,
    input  logic                    pol_drop,

    output logic                    out_valid,
    output policer_pkg::beat_data_t out_data,
    output logic                    out_last,
    output policer_pkg::port_id_t   out_port,
    output policer_pkg::byte_len_t  out_len,

    output logic                    fate_valid,
    output logic                    fate_drop,
    output policer_pkg::port_id_t   fate_port
);

    import policer_pkg::*;

    logic sop;
    logic first_beat;
    logic drop_hold;   // verdict of the packet in flight.
    logic pkt_drop;

    assign first_beat = pol_valid && sop;
    assign pkt_drop   = first_beat ? pol_drop : drop_hold;

    // ~~~~~~~~~~~~~~~~~~~~
    // packet tracking
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            sop        <= 1'b1;
            drop_hold  <= 1'b0;
            out_valid  <= 1'b0;
            fate_valid <= 1'b0;
        end else begin
            out_valid  <= pol_valid && !pkt_drop;
            fate_valid <= first_beat;  // one strobe per packet.
            if (first_beat) begin
                drop_hold <= pol_drop;
            end
            if (pol_valid) begin
                sop <= pol_last;
            end
        end
    end

    // fate fields only mean something alongside fate_valid.
    always_ff @(posedge packet_in) begin
        if (first_beat) begin
            fate_drop <= pol_drop;
            fate_port <= pol_port;
        end
        if (pol_valid) begin
            out_data <= pol_data;
            out_last <= pol_last;
            out_port <= pol_port;
            out_len  <= pol_len;
        end
    end

endmodule

/* policer/bucket_policer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// one leaky bucket per port. in_port and in_len must hold for a whole packet.
// pol_drop is only valid on the first beat of a packet.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "policer_defines.svh"

module bucket_policer (
    input  logic                           packet_in,
    input  logic                           rst_n,

    input  logic [`POLICER_NUM_PORTS-1:0]  port_enable,
    input  policer_pkg::bucket_decrement_t port_decrement [`POLICER_NUM_PORTS],
    input  policer_pkg::bucket_threshold_t port_threshold [`POLICER_NUM_PORTS],

    input  logic                           in_valid,
    input  policer_pkg::beat_data_t        in_data,
    input  logic                           in_last,
    input  policer_pkg::port_id_t          in_port,
    input  policer_pkg::byte_len_t         in_len,

    output logic                           pol_valid,
    output policer_pkg::beat_data_t        pol_data,
    output logic                           pol_last,
    output policer_pkg::port_id_t          pol_port,
    output policer_pkg::byte_len_t         pol_len,
    output logic                           pol_drop
);

    import policer_pkg::*;

    localparam int NUM_PORTS = `POLICER_NUM_PORTS;
    localparam int SUM_W     = `POLICER_BUCKET_W + 1;  // room for bucket plus length.

    bucket_t          bucket     [NUM_PORTS];
    bucket_t          bucket_nxt [NUM_PORTS];
    logic [SUM_W-1:0] charged    [NUM_PORTS];
    logic             sop;
    logic             first_beat;
    logic             drop_nxt;

    // level minus leak, floored at zero.
    function automatic bucket_t leak(input logic [SUM_W-1:0] level,
                                     input bucket_decrement_t dec);
        if (level > SUM_W'(dec)) begin
            return bucket_t'(level - SUM_W'(dec));
        end
        return '0;
    endfunction

    assign first_beat = in_valid && sop;

    // ~~~~~~~~~~~~~~~~~~~~
    // bucket update
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        drop_nxt = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            charged[p]    = SUM_W'(bucket[p]) + SUM_W'(in_len);
            bucket_nxt[p] = leak(SUM_W'(bucket[p]), port_decrement[p]);
            if (!port_enable[p]) begin
                bucket_nxt[p] = '0;  // disabled port never drops.
            end else if (first_beat && in_port == port_id_t'(p)) begin
                if (charged[p] > SUM_W'(port_threshold[p])) begin
                    drop_nxt = 1'b1;  // over rate, bucket just leaks.
                end else begin
                    bucket_nxt[p] = leak(charged[p], port_decrement[p]);
                end
            end
        end
    end

    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            bucket    <= '{default: '0};
            sop       <= 1'b1;
            pol_valid <= 1'b0;
            pol_drop  <= 1'b0;
        end else begin
            bucket    <= bucket_nxt;
            pol_valid <= in_valid;
            pol_drop  <= drop_nxt;
            if (in_valid) begin
                sop <= in_last;  // next beat opens a packet.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // beat delay
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge packet_in) begin
        if (in_valid) begin
            pol_data <= in_data;
            pol_last <= in_last;
            pol_port <= in_port;
            pol_len  <= in_len;
        end
    end

endmodule

/* design/policer_config_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~
// per-port policy registers. a write is visible the cycle after cfg_wr.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "policer_defines.svh"

module policer_config_regs (
    input  logic                           packet_in,
    input  logic                           rst_n,

    input  logic                           cfg_wr,
    input  policer_pkg::port_id_t          cfg_port,
    input  policer_pkg::cfg_field_e        cfg_field,
    input  logic [`POLICER_BUCKET_W-1:0]   cfg_wdata,

    output logic [`POLICER_NUM_PORTS-1:0]  port_enable,
    output policer_pkg::bucket_decrement_t port_decrement [`POLICER_NUM_PORTS],
    output policer_pkg::bucket_threshold_t port_threshold [`POLICER_NUM_PORTS]
);

    import policer_pkg::*;

    localparam int NUM_PORTS = `POLICER_NUM_PORTS;

    // ~~~~~~~~~~~~~~~~~~~~
    // write decode
    // ~~~~~~~~~~~~~~~~~~~~

    logic [NUM_PORTS-1:0] port_hit;

    always_comb begin
        port_hit = '0;
        if (cfg_wr) begin
            port_hit[cfg_port] = 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // register storage
    // ~~~~~~~~~~~~~~~~~~~~

    // all ports come up disabled with an empty policy.
    always_ff @(posedge packet_in or negedge rst_n) begin
        if (!rst_n) begin
            port_enable    <= '0;
            port_decrement <= '{default: '0};
            port_threshold <= '{default: '0};
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (port_hit[p]) begin
                    case (cfg_field)
                        CFG_ENABLE: begin
                            port_enable[p] <= cfg_wdata[0];
                        end
                        CFG_DECREMENT: begin
                            // decrement is narrower than the write bus.
                            port_decrement[p] <= bucket_decrement_t'(
                                cfg_wdata[`POLICER_LEN_W-1:0]);
                        end
                        CFG_THRESHOLD: begin
                            port_threshold[p] <= bucket_threshold_t'(cfg_wdata);
                        end
                        default: begin
                            // unused field code, write ignored.
                        end
                    endcase
                end
            end
        end
    end

endmodule

/* common/policer_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// types of the policer datapath, sized from the defines header.
// ~~~~~~~~~~~~~~~~~~~~

`include "policer_defines.svh"

package policer_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // packet fields
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [$clog2(`POLICER_NUM_PORTS)-1:0] port_id_t;
    typedef logic [`POLICER_LEN_W-1:0]             byte_len_t;
    typedef logic [`POLICER_DATA_W-1:0]            beat_data_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // bucket state and policy
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [`POLICER_BUCKET_W-1:0] bucket_t;
    typedef logic [`POLICER_LEN_W-1:0]    bucket_decrement_t;  // leak per cycle.
    typedef logic [`POLICER_BUCKET_W-1:0] bucket_threshold_t;

    // per-port packet counters, saturating.
    typedef logic [15:0] stat_count_t;

    // register targeted by a config write.
    typedef enum logic [1:0] {
        CFG_ENABLE    = 2'd0,
        CFG_DECREMENT = 2'd1,
        CFG_THRESHOLD = 2'd2
    } cfg_field_e;

endpackage

/* common/policer_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~
// sizes shared by the policer RTL and its testbench.
// port ids are 2 bits wide, so the port count must stay at 4 or below.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef POLICER_DEFINES_SVH
`define POLICER_DEFINES_SVH

// ingress ports, one bucket each.
`define POLICER_NUM_PORTS 4

// one beat per cycle.
`define POLICER_DATA_W 64

// packet byte length as delivered with every beat.
`define POLICER_LEN_W 16

// bucket level and threshold.
// needs headroom over the length width so one packet cannot wrap a bucket.
`define POLICER_BUCKET_W 20

`endif
